// ==== source/isa_pkg.sv ====
package isa_pkg;

	// R-type: register to register, function in the low six bits
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	// I-type: rt is the destination
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	// Same 32-bit word, two views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_t;

	// Major opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_LUI     = 6'h0f;

	// SPECIAL function codes
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

// ==== source/core_pkg.sv ====
package core_pkg;

	localparam int WORD_W     = 32;
	localparam int ADDR_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 1 << REG_ADDR_W;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [ADDR_W-1:0]     inst_addr_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// Internal ALU operations, decoupled from the ISA encodings
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5,
		ALU_LUI = 3'd6
	} alu_op_t;

endpackage

// ==== source/fetch_unit.sv ====
module fetch_unit #(
	parameter core_pkg::inst_addr_t RESET_PC = 32'hbfc0_0000
)(
	input  logic                 clk,
	input  logic                 arst_n,
	output logic                 imem_req,
	output core_pkg::inst_addr_t imem_addr,
	input  core_pkg::word_t      imem_rdata,
	input  logic                 imem_ack,
	output logic                 if_valid,
	output core_pkg::inst_addr_t if_pc,
	output core_pkg::word_t      if_instr
);

	localparam logic [1:0] S_START     = 2'd0;
	localparam logic [1:0] S_REQ       = 2'd1;
	localparam logic [1:0] S_WAIT_DROP = 2'd2;

	logic [1:0]           state;
	core_pkg::inst_addr_t pc;
	logic                 capture;

	// Address only moves on the capture edge, so it is stable under req
	assign imem_req  = (state == S_REQ);
	assign imem_addr = pc;
	assign capture   = (state == S_REQ) && imem_ack;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= S_START;
			pc       <= RESET_PC;
			if_valid <= 1'b0;
		end
		else
		begin
			if_valid <= capture;
			case (state)
				// Raise req again only once ack has been seen low
				S_START, S_WAIT_DROP:
				begin
					if (!imem_ack)
						state <= S_REQ;
				end
				S_REQ:
				begin
					if (imem_ack)
					begin
						state <= S_WAIT_DROP;
						pc    <= pc + 32'd4;
					end
				end
				default:
					state <= S_START;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			if_pc    <= pc;
			if_instr <= imem_rdata;
		end
	end

endmodule

// ==== source/decode_stage.sv ====
module decode_stage (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 if_valid,
	input  core_pkg::inst_addr_t if_pc,
	input  core_pkg::word_t      if_instr,
	output core_pkg::reg_addr_t  rs_addr,
	output core_pkg::reg_addr_t  rt_addr,
	input  core_pkg::word_t      rs_data,
	input  core_pkg::word_t      rt_data,
	input  logic                 ex_fwd_we,
	input  core_pkg::reg_addr_t  ex_fwd_addr,
	input  core_pkg::word_t      ex_fwd_data,
	input  logic                 wb_we,
	input  core_pkg::reg_addr_t  wb_waddr,
	input  core_pkg::word_t      wb_wdata,
	output logic                 ex_valid,
	output core_pkg::inst_addr_t ex_pc,
	output core_pkg::alu_op_t    ex_op,
	output core_pkg::word_t      ex_a,
	output core_pkg::word_t      ex_b,
	output logic                 ex_we,
	output core_pkg::reg_addr_t  ex_waddr
);

	isa_pkg::instr_t     instr;
	core_pkg::alu_op_t   dec_op;
	logic                dec_we;
	logic                dec_use_imm;
	core_pkg::reg_addr_t dec_waddr;
	core_pkg::word_t     imm_ext;
	core_pkg::word_t     opnd_a;
	core_pkg::word_t     opnd_b;

	// EX beats WB and WB beats the array
	function automatic core_pkg::word_t pick_operand(
		input core_pkg::reg_addr_t addr,
		input core_pkg::word_t     rf_data
	);
		if (ex_fwd_we && ex_fwd_addr == addr)
			return ex_fwd_data;
		else if (wb_we && wb_waddr == addr)
			return wb_wdata;
		else
			return rf_data;
	endfunction

	assign instr   = if_instr;
	assign rs_addr = instr.r.rs;
	assign rt_addr = instr.r.rt;

	always_comb
	begin
		dec_op      = core_pkg::ALU_ADD;
		dec_we      = 1'b0;
		dec_use_imm = 1'b0;
		dec_waddr   = instr.r.rd;
		imm_ext     = {{(core_pkg::WORD_W-16){instr.i.imm[15]}}, instr.i.imm};
		case (instr.r.opcode)
			isa_pkg::OP_SPECIAL:
			begin
				dec_we = 1'b1;
				case (instr.r.funct)
					isa_pkg::FN_ADDU: dec_op = core_pkg::ALU_ADD;
					isa_pkg::FN_SUBU: dec_op = core_pkg::ALU_SUB;
					isa_pkg::FN_AND:  dec_op = core_pkg::ALU_AND;
					isa_pkg::FN_OR:   dec_op = core_pkg::ALU_OR;
					isa_pkg::FN_XOR:  dec_op = core_pkg::ALU_XOR;
					isa_pkg::FN_SLT:  dec_op = core_pkg::ALU_SLT;
					default:          dec_we = 1'b0;
				endcase
			end
			isa_pkg::OP_ADDIU:
			begin
				dec_we      = 1'b1;
				dec_use_imm = 1'b1;
				dec_waddr   = instr.i.rt;
			end
			isa_pkg::OP_ORI, isa_pkg::OP_LUI:
			begin
				dec_op      = (instr.i.opcode == isa_pkg::OP_ORI) ?
					core_pkg::ALU_OR : core_pkg::ALU_LUI;
				dec_we      = 1'b1;
				dec_use_imm = 1'b1;
				dec_waddr   = instr.i.rt;
				imm_ext     = {{(core_pkg::WORD_W-16){1'b0}}, instr.i.imm};
			end
			default:
				dec_we = 1'b0;
		endcase
		// r0 stays zero
		if (dec_waddr == '0)
			dec_we = 1'b0;
	end

	always_comb
	begin
		opnd_a = pick_operand(rs_addr, rs_data);
		opnd_b = dec_use_imm ? imm_ext : pick_operand(rt_addr, rt_data);
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ex_valid <= 1'b0;
			ex_we    <= 1'b0;
		end
		else
		begin
			ex_valid <= if_valid;
			ex_we    <= if_valid && dec_we;
		end
	end

	always_ff @(posedge clk)
	begin
		if (if_valid)
		begin
			ex_pc    <= if_pc;
			ex_op    <= dec_op;
			ex_a     <= opnd_a;
			ex_b     <= opnd_b;
			ex_waddr <= dec_waddr;
		end
	end

endmodule

// ==== source/reg_file.sv ====
module reg_file (
	input  logic                clk,
	input  logic                arst_n,
	input  core_pkg::reg_addr_t rs_addr,
	input  core_pkg::reg_addr_t rt_addr,
	output core_pkg::word_t     rs_data,
	output core_pkg::word_t     rt_data,
	input  logic                we,
	input  core_pkg::reg_addr_t waddr,
	input  core_pkg::word_t     wdata
);

	// No storage behind r0
	core_pkg::word_t regs [1:core_pkg::NUM_REGS-1];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 1; i < core_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (we && waddr != '0)
		begin
			regs[waddr] <= wdata;
		end
	end

	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// ==== source/alu_stage.sv ====
module alu_stage (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 ex_valid,
	input  core_pkg::inst_addr_t ex_pc,
	input  core_pkg::alu_op_t    ex_op,
	input  core_pkg::word_t      ex_a,
	input  core_pkg::word_t      ex_b,
	input  logic                 ex_we,
	input  core_pkg::reg_addr_t  ex_waddr,
	output logic                 ex_fwd_we,
	output core_pkg::reg_addr_t  ex_fwd_addr,
	output core_pkg::word_t      ex_fwd_data,
	output logic                 wb_valid,
	output core_pkg::inst_addr_t wb_pc,
	output logic                 wb_we,
	output core_pkg::reg_addr_t  wb_waddr,
	output core_pkg::word_t      wb_wdata
);

	core_pkg::word_t result;

	always_comb
	begin
		case (ex_op)
			core_pkg::ALU_ADD: result = ex_a + ex_b;
			core_pkg::ALU_SUB: result = ex_a - ex_b;
			core_pkg::ALU_AND: result = ex_a & ex_b;
			core_pkg::ALU_OR:  result = ex_a | ex_b;
			core_pkg::ALU_XOR: result = ex_a ^ ex_b;
			core_pkg::ALU_SLT: result = core_pkg::word_t'($signed(ex_a) < $signed(ex_b));
			// Immediate arrives zero-extended in b
			core_pkg::ALU_LUI: result = ex_b << 16;
			default:           result = '0;
		endcase
	end

	assign ex_fwd_we   = ex_valid && ex_we;
	assign ex_fwd_addr = ex_waddr;
	assign ex_fwd_data = result;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wb_valid <= 1'b0;
			wb_we    <= 1'b0;
		end
		else
		begin
			wb_valid <= ex_valid;
			wb_we    <= ex_valid && ex_we;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ex_valid)
		begin
			wb_pc    <= ex_pc;
			wb_waddr <= ex_waddr;
			wb_wdata <= result;
		end
	end

endmodule

// ==== source/mini_mips.sv ====
module mini_mips #(
	parameter core_pkg::inst_addr_t RESET_PC = 32'hbfc0_0000
)(
	input  logic                 clk,
	input  logic                 arst_n,
	output logic                 imem_req,
	output core_pkg::inst_addr_t imem_addr,
	input  core_pkg::word_t      imem_rdata,
	input  logic                 imem_ack,
	output logic                 debug_wb_valid,
	output core_pkg::inst_addr_t debug_wb_pc,
	output logic                 debug_wb_we,
	output core_pkg::reg_addr_t  debug_wb_addr,
	output core_pkg::word_t      debug_wb_wdata
);

	logic                 if_valid;
	core_pkg::inst_addr_t if_pc;
	core_pkg::word_t      if_instr;

	core_pkg::reg_addr_t  rs_addr;
	core_pkg::reg_addr_t  rt_addr;
	core_pkg::word_t      rs_data;
	core_pkg::word_t      rt_data;

	logic                 ex_valid;
	core_pkg::inst_addr_t ex_pc;
	core_pkg::alu_op_t    ex_op;
	core_pkg::word_t      ex_a;
	core_pkg::word_t      ex_b;
	logic                 ex_we;
	core_pkg::reg_addr_t  ex_waddr;

	logic                 ex_fwd_we;
	core_pkg::reg_addr_t  ex_fwd_addr;
	core_pkg::word_t      ex_fwd_data;

	fetch_unit #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clk,
		.arst_n,
		.imem_req,
		.imem_addr,
		.imem_rdata,
		.imem_ack,
		.if_valid,
		.if_pc,
		.if_instr
	);

	decode_stage u_decode (
		.clk,
		.arst_n,
		.if_valid,
		.if_pc,
		.if_instr,
		.rs_addr,
		.rt_addr,
		.rs_data,
		.rt_data,
		.ex_fwd_we,
		.ex_fwd_addr,
		.ex_fwd_data,
		.wb_we(debug_wb_we),
		.wb_waddr(debug_wb_addr),
		.wb_wdata(debug_wb_wdata),
		.ex_valid,
		.ex_pc,
		.ex_op,
		.ex_a,
		.ex_b,
		.ex_we,
		.ex_waddr
	);

	// Writeback is the EX/WB register driving the array directly
	reg_file u_regs (
		.clk,
		.arst_n,
		.rs_addr,
		.rt_addr,
		.rs_data,
		.rt_data,
		.we(debug_wb_we),
		.waddr(debug_wb_addr),
		.wdata(debug_wb_wdata)
	);

	alu_stage u_alu (
		.clk,
		.arst_n,
		.ex_valid,
		.ex_pc,
		.ex_op,
		.ex_a,
		.ex_b,
		.ex_we,
		.ex_waddr,
		.ex_fwd_we,
		.ex_fwd_addr,
		.ex_fwd_data,
		.wb_valid(debug_wb_valid),
		.wb_pc(debug_wb_pc),
		.wb_we(debug_wb_we),
		.wb_waddr(debug_wb_addr),
		.wb_wdata(debug_wb_wdata)
	);

endmodule

// ==== verif/mini_mips_props.sv ====
module mini_mips_props (
	input logic                 clk,
	input logic                 arst_n,
	input logic                 imem_req,
	input logic                 imem_ack,
	input core_pkg::inst_addr_t imem_addr
);

	timeunit 1ns;
	timeprecision 100ps;

	// Request stays up until the memory answers
	req_held_until_ack: assert property (
		@(posedge clk) disable iff (!arst_n)
		imem_req && !imem_ack |=> imem_req
	) else $error("imem_req dropped before imem_ack");

	addr_stable_under_req: assert property (
		@(posedge clk) disable iff (!arst_n)
		imem_req && !imem_ack |=> $stable(imem_addr)
	) else $error("imem_addr changed while imem_req was waiting");

	// Next request only after ack has gone low
	no_req_while_ack: assert property (
		@(posedge clk) disable iff (!arst_n)
		!imem_req && imem_ack |=> !imem_req
	) else $error("imem_req raised while imem_ack still high");

	req_low_in_reset: assert property (
		@(posedge clk)
		!arst_n |-> !imem_req
	) else $error("imem_req high during reset");

endmodule

bind fetch_unit mini_mips_props u_props (
	.clk,
	.arst_n,
	.imem_req,
	.imem_ack,
	.imem_addr
);

// ==== verif/tb_mini_mips.sv ====
module tb_mini_mips;

	timeunit 1ns;
	timeprecision 100ps;

	localparam core_pkg::inst_addr_t RESET_PC = 32'h0040_0000;
	localparam int PROG_LEN       = 400;
	localparam int TIMEOUT_CYCLES = PROG_LEN * 12 + 100;

	logic                 clk;
	logic                 arst_n;
	logic                 imem_req;
	core_pkg::inst_addr_t imem_addr;
	core_pkg::word_t      imem_rdata;
	logic                 imem_ack;
	logic                 debug_wb_valid;
	core_pkg::inst_addr_t debug_wb_pc;
	logic                 debug_wb_we;
	core_pkg::reg_addr_t  debug_wb_addr;
	core_pkg::word_t      debug_wb_wdata;

	core_pkg::word_t prog [0:PROG_LEN-1];
	core_pkg::word_t model_regs [0:31];
	logic [31:0]     rng_state;
	int              retired;
	int              cycles = 0;

	mini_mips #(
		.RESET_PC(RESET_PC)
	) u_dut (
		.clk,
		.arst_n,
		.imem_req,
		.imem_addr,
		.imem_rdata,
		.imem_ack,
		.debug_wb_valid,
		.debug_wb_pc,
		.debug_wb_we,
		.debug_wb_addr,
		.debug_wb_wdata
	);

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic int random_delay();
		return int'(next_random() % 32'd4);
	endfunction

	// Mostly supported ops on r0..r7, so dependencies are frequent
	function automatic core_pkg::word_t random_instr();
		logic [31:0] r;
		logic [31:0] sel;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		r = next_random();
		if (r % 32'd10 == 32'd0)
			return next_random();
		sel = next_random();
		rs  = {2'b00, sel[2:0]};
		rt  = {2'b00, sel[5:3]};
		rd  = {2'b00, sel[8:6]};
		imm = sel[31:16];
		case (r % 32'd9)
			32'd0:   return {isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, isa_pkg::FN_ADDU};
			32'd1:   return {isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, isa_pkg::FN_SUBU};
			32'd2:   return {isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, isa_pkg::FN_AND};
			32'd3:   return {isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, isa_pkg::FN_OR};
			32'd4:   return {isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, isa_pkg::FN_XOR};
			32'd5:   return {isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, isa_pkg::FN_SLT};
			32'd6:   return {isa_pkg::OP_ADDIU, rs, rt, imm};
			32'd7:   return {isa_pkg::OP_ORI, rs, rt, imm};
			default: return {isa_pkg::OP_LUI, 5'd0, rt, imm};
		endcase
	endfunction

	// Reference behavior of one instruction against the model registers
	task automatic expected_result(
		input  core_pkg::word_t     instr,
		output logic                we,
		output core_pkg::reg_addr_t dest,
		output core_pkg::word_t     value
	);
		logic [5:0]      op;
		logic [5:0]      funct;
		logic [15:0]     imm;
		core_pkg::word_t a;
		core_pkg::word_t b;
		op    = instr[31:26];
		funct = instr[5:0];
		imm   = instr[15:0];
		a     = model_regs[instr[25:21]];
		b     = model_regs[instr[20:16]];
		we    = 1'b1;
		dest  = instr[20:16];
		value = '0;
		case (op)
			isa_pkg::OP_SPECIAL:
			begin
				dest = instr[15:11];
				case (funct)
					isa_pkg::FN_ADDU: value = a + b;
					isa_pkg::FN_SUBU: value = a - b;
					isa_pkg::FN_AND:  value = a & b;
					isa_pkg::FN_OR:   value = a | b;
					isa_pkg::FN_XOR:  value = a ^ b;
					isa_pkg::FN_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:          we = 1'b0;
				endcase
			end
			isa_pkg::OP_ADDIU: value = a + {{16{imm[15]}}, imm};
			isa_pkg::OP_ORI:   value = a | {16'h0000, imm};
			isa_pkg::OP_LUI:   value = {imm, 16'h0000};
			default:           we = 1'b0;
		endcase
		if (dest == 5'd0)
			we = 1'b0;
	endtask

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_word(input core_pkg::word_t got, input core_pkg::word_t exp,
		input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input core_pkg::reg_addr_t got, input core_pkg::reg_addr_t exp,
		input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: %s is r%0d, expected r%0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_pc(input core_pkg::inst_addr_t got, input core_pkg::inst_addr_t exp,
		input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_retirement();
		logic                exp_we;
		core_pkg::reg_addr_t exp_dest;
		core_pkg::word_t     exp_value;
		if (retired >= PROG_LEN)
		begin
			$display("Instruction retired past the end of the program, PC %h", debug_wb_pc);
			abort_run();
		end
		else
		begin
			check_pc(debug_wb_pc, RESET_PC + core_pkg::inst_addr_t'(retired * 4),
				"writeback PC");
			expected_result(prog[retired], exp_we, exp_dest, exp_value);
			check_bit(debug_wb_we, exp_we, "writeback enable");
			if (exp_we)
			begin
				check_addr(debug_wb_addr, exp_dest, "writeback register");
				check_word(debug_wb_wdata, exp_value, "writeback data");
				model_regs[exp_dest] = exp_value;
			end
			retired++;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		arst_n     = 1'b0;
		imem_ack   = 1'b0;
		imem_rdata = '0;
		rng_state  = 32'd89;
		retired    = 0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		for (int i = 0; i < PROG_LEN; i++)
			prog[i] = random_instr();
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
		wait (retired == PROG_LEN);
		repeat (4) @(negedge clk);
		$display("Test completed successfully");
		$finish;
	end

	// Memory side of the four-phase handshake, past the program it never answers
	initial
	begin
		int idx;
		wait (arst_n === 1'b1);
		forever
		begin
			@(negedge clk);
			if (imem_req && !imem_ack)
			begin
				idx = int'((imem_addr - RESET_PC) >> 2);
				if (idx < PROG_LEN)
				begin
					repeat (random_delay()) @(negedge clk);
					imem_rdata = prog[idx];
					imem_ack   = 1'b1;
					while (imem_req)
						@(negedge clk);
					repeat (random_delay()) @(negedge clk);
					imem_ack = 1'b0;
				end
			end
		end
	end

	// Outputs are registered, so the falling edge sees them settled
	always @(negedge clk)
	begin
		if (arst_n && debug_wb_valid)
			check_retirement();
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: %0d of %0d instructions retired after %0d cycles",
				retired, PROG_LEN, cycles);
			abort_run();
		end
	end

endmodule

// ==== compile.f ====
source/isa_pkg.sv
source/core_pkg.sv
source/fetch_unit.sv
source/decode_stage.sv
source/reg_file.sv
source/alu_stage.sv
source/mini_mips.sv
verif/mini_mips_props.sv
verif/tb_mini_mips.sv

// ==== Makefile ====
TOP = tb_mini_mips

.PHONY: all compile run pass clean

all: pass

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log

pass: run
	@if grep -q "Test failed" sim.log; then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "Test completed successfully" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi
	@echo "Simulation PASSED"

clean:
	rm -rf obj_dir sim.log
